// File: files.f
rtl/cpu_pkg.sv
rtl/ex_mem_if.sv
rtl/mem_wb_if.sv
rtl/data_ram.sv
rtl/mem_access.sv
rtl/mem_wb.sv
rtl/writeback.sv
rtl/reg_file.sv
rtl/cpu_backend.sv
tests/tb_cpu_backend.sv

// File: Bender.yml
package:
  name: cpu_backend

sources:
  - rtl/cpu_pkg.sv
  - rtl/ex_mem_if.sv
  - rtl/mem_wb_if.sv
  - rtl/data_ram.sv
  - rtl/mem_access.sv
  - rtl/mem_wb.sv
  - rtl/writeback.sv
  - rtl/reg_file.sv
  - rtl/cpu_backend.sv
  - target: test
    files:
      - tests/tb_cpu_backend.sv

// File: tests/tb_cpu_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_backend
    import cpu_pkg::*;
();

    localparam int data_depth    = 256;
    localparam int warmup_cycles = 3;
    localparam int max_cycles    = 400;

    logic     clk;
    logic     reset_n;
    logic     ex_valid;
    word_t    ex_pc;
    opcode_e  ex_opcode;
    func_e    ex_func;
    reg_idx_t ex_rd;
    word_t    ex_alu_result;
    word_t    ex_store_data;
    word_t    ex_r_data1;
    reg_idx_t rs_addr;
    reg_idx_t rt_addr;
    word_t    rs_data;
    word_t    rt_data;
    word_t    output_port;
    word_t    num_inst;
    logic     is_halted;

    // Reference model
    word_t model_regs [4];
    word_t model_ram [data_depth];
    word_t model_out;
    word_t model_num_inst;
    logic  model_halted;

    logic [15:0] lfsr_state;
    int          edge_count;   // Edges since reset release
    int          cycle_count;
    int          error_count;
    int          check_count;
    word_t       pc_count;

    cpu_backend #(
        .data_depth    (data_depth),
        .warmup_cycles (warmup_cycles)
    ) dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_opcode     (ex_opcode),
        .ex_func       (ex_func),
        .ex_rd         (ex_rd),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_r_data1    (ex_r_data1),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .output_port   (output_port),
        .num_inst      (num_inst),
        .is_halted     (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_n) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: cycle limit reached before the tests finished");
            $display("Simulation FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic func_e pick_func(input logic [2:0] sel);
        case (sel)
            3'd0:    return fn_add;
            3'd1:    return fn_sub;
            3'd2:    return fn_and;
            3'd3:    return fn_orr;
            3'd4:    return fn_not;
            3'd5:    return fn_tcp;
            3'd6:    return fn_shl;
            default: return fn_shr;
        endcase
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        reset_n = 1'b1;
        repeat (3) @(negedge clk);
        reset_n = 1'b0;
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        model_out      = '0;
        model_num_inst = '0;
        model_halted   = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // The op is sampled at the rising edge after the call
    task automatic issue_op(input opcode_e opcode, input func_e func, input reg_idx_t rd,
                            input word_t alu_result, input word_t store_data,
                            input word_t r_data1);
        logic [7:0] addr;
        addr          = alu_result[7:0];
        ex_valid      = 1'b1;
        ex_pc         = pc_count;
        ex_opcode     = opcode;
        ex_func       = func;
        ex_rd         = rd;
        ex_alu_result = alu_result;
        ex_store_data = store_data;
        ex_r_data1    = r_data1;
        pc_count      = pc_count + 1'b1;
        if (edge_count + 1 > warmup_cycles && !model_halted) begin
            if (opcode == op_swd) begin
                model_ram[addr] = store_data;
            end else if (opcode == op_rtype && func == fn_wwd) begin
                model_out = r_data1;
            end else if (opcode == op_rtype && func == fn_hlt) begin
                model_halted = 1'b1;
            end else if (opcode == op_lwd) begin
                model_regs[rd] = model_ram[addr];
            end else begin
                model_regs[rd] = alu_result;
            end
            model_num_inst = model_num_inst + 1'b1;
        end
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic random_alu_op(input reg_idx_t rd);
        logic [1:0] sel;
        opcode_e    opcode;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    opcode = op_adi;
            2'd1:    opcode = op_ori;
            2'd2:    opcode = op_lhi;
            default: opcode = op_rtype;
        endcase
        issue_op(opcode, pick_func(3'(rand_bits(3))), rd, rand_bits(16), rand_bits(16),
                 rand_bits(16));
    endtask

    // Sweeps both read ports, then compares the counters
    task automatic check_state();
        logic [1:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx     = 2'(i);
            rs_addr = idx;
            rt_addr = ~idx;
            @(negedge clk);
            compare_word($sformatf("rs_data[%0d]", idx), model_regs[idx], rs_data);
            compare_word($sformatf("rt_data[%0d]", ~idx), model_regs[~idx], rt_data);
        end
        compare_word("num_inst", model_num_inst, num_inst);
        compare_word("output_port", model_out, output_port);
        compare_word("is_halted", {15'd0, model_halted}, {15'd0, is_halted});
    endtask

    task automatic warmup_drops_ops();
        for (int i = 0; i < warmup_cycles; i++) begin
            issue_op(op_adi, fn_add, 2'(i), rand_bits(16) | 16'h1, '0, '0);
        end
        // First edge after the window
        issue_op(op_ori, fn_add, 2'd3, rand_bits(16) | 16'h1, '0, '0);
        idle(3);
        check_state();
    endtask

    task automatic write_registers();
        for (int i = 0; i < 16; i++) begin
            random_alu_op(2'(i));
        end
        idle(3);
        check_state();
    endtask

    task automatic store_then_load();
        logic [7:0] addrs [4];
        for (int i = 0; i < 4; i++) begin
            addrs[i] = 8'(rand_bits(8));
            issue_op(op_swd, fn_add, 2'(i), {8'd0, addrs[i]}, rand_bits(16), '0);
        end
        idle(3);
        check_state(); // Stores leave registers alone
        for (int i = 0; i < 4; i++) begin
            issue_op(op_lwd, fn_add, 2'(i), {8'd0, addrs[3 - i]}, '0, '0);
        end
        idle(3);
        check_state();
    endtask

    task automatic bubbles_hold_state();
        for (int i = 0; i < 2; i++) begin
            random_alu_op(2'(rand_bits(2)));
            idle(3);
            check_state();
            idle(4);
            check_state();
        end
    endtask

    task automatic wwd_drives_port();
        for (int i = 0; i < 3; i++) begin
            issue_op(op_rtype, fn_wwd, 2'(i), rand_bits(16), '0, rand_bits(16));
        end
        idle(3);
        check_state();
    endtask

    task automatic halt_freezes_state();
        issue_op(op_rtype, fn_hlt, 2'd1, rand_bits(16), '0, '0);
        idle(3);
        check_state();
        issue_op(op_adi, fn_add, 2'd0, rand_bits(16), '0, '0);
        issue_op(op_rtype, fn_wwd, 2'd2, rand_bits(16), '0, rand_bits(16));
        issue_op(op_rtype, fn_sub, 2'd3, rand_bits(16), '0, '0);
        idle(3);
        check_state();
        apply_reset();
        check_state(); // Fresh reset clears halt, counters and registers
    endtask

    initial begin
        reset_n       = 1'b1;
        ex_valid      = 1'b0;
        ex_pc         = '0;
        ex_opcode     = op_adi;
        ex_func       = fn_add;
        ex_rd         = '0;
        ex_alu_result = '0;
        ex_store_data = '0;
        ex_r_data1    = '0;
        rs_addr       = '0;
        rt_addr       = '0;
        lfsr_state    = 16'd18692;
        edge_count    = 0;
        cycle_count   = 0;
        error_count   = 0;
        check_count   = 0;
        pc_count      = '0;

        apply_reset();
        warmup_drops_ops();
        write_registers();
        store_then_load();
        bubbles_hold_state();
        wwd_drives_port();
        halt_freezes_state();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/cpu_backend.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend
    import cpu_pkg::*;
#(
    parameter int data_depth    = 256,
    parameter int warmup_cycles = 3
) (
    input  wire           clk,
    input  wire           reset_n,
    input  wire           ex_valid,
    input  wire word_t    ex_pc,
    input  wire opcode_e  ex_opcode,
    input  wire func_e    ex_func,
    input  wire reg_idx_t ex_rd,
    input  wire word_t    ex_alu_result,
    input  wire word_t    ex_store_data,
    input  wire word_t    ex_r_data1,
    input  wire reg_idx_t rs_addr,
    input  wire reg_idx_t rt_addr,
    output word_t         rs_data,
    output word_t         rt_data,
    output word_t         output_port,
    output word_t         num_inst,
    output logic          is_halted
);

    ex_mem_if ex_mem ();
    mem_wb_if mem_stage ();  // Before the MEM/WB register
    mem_wb_if wb_stage ();   // After it

    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    assign ex_mem.valid      = ex_valid;
    assign ex_mem.pc         = ex_pc;
    assign ex_mem.opcode     = ex_opcode;
    assign ex_mem.func       = ex_func;
    assign ex_mem.rd         = ex_rd;
    assign ex_mem.alu_result = ex_alu_result;
    assign ex_mem.store_data = ex_store_data;
    assign ex_mem.r_data1    = ex_r_data1;

    mem_access #(
        .data_depth (data_depth)
    ) mem_access_i (
        .clk     (clk),
        .reset_n (reset_n),
        .ex      (ex_mem.dst),
        .mw      (mem_stage.src)
    );

    mem_wb #(
        .warmup_cycles (warmup_cycles)
    ) mem_wb_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_stage  (mem_stage.dst),
        .out_stage (wb_stage.src)
    );

    writeback writeback_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .wb          (wb_stage.dst),
        .we          (rf_we),
        .waddr       (rf_waddr),
        .wdata       (rf_wdata),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .reset_n (reset_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           we,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata,
    input  wire reg_idx_t rs_addr,
    input  wire reg_idx_t rt_addr,
    output word_t         rs_data,
    output word_t         rt_data
);

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // A write shows only after the edge
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: rtl/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback
    import cpu_pkg::*;
(
    input wire       clk,
    input wire       reset_n,
    mem_wb_if.dst    wb,
    output logic     we,
    output reg_idx_t waddr,
    output word_t    wdata,
    output word_t    output_port,
    output word_t    num_inst,
    output logic     is_halted
);

    logic retire;
    logic is_store;
    logic is_wwd;
    logic is_hlt;

    assign retire   = wb.valid && !is_halted;
    assign is_store = (wb.opcode == op_swd);
    assign is_wwd   = (wb.opcode == op_rtype) && (wb.func == fn_wwd);
    assign is_hlt   = (wb.opcode == op_rtype) && (wb.func == fn_hlt);

    // Register file samples these on the same edge as num_inst
    assign we    = retire && !is_store && !is_wwd && !is_hlt;
    assign waddr = wb.rd;
    assign wdata = wb.result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_port <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else if (retire) begin
            num_inst <= num_inst + 1'b1;
            if (is_wwd) begin
                output_port <= wb.r_data1;
            end
            if (is_hlt) begin
                is_halted <= 1'b1; // Sticky until reset
            end
        end
    end

    a_halt_sticky: assert property (@(posedge clk)
        $fell(is_halted) |-> $past(reset_n));

endmodule

`default_nettype wire

// File: rtl/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb
    import cpu_pkg::*;
#(
    parameter int warmup_cycles = 3
) (
    input wire    clk,
    input wire    reset_n,
    mem_wb_if.dst in_stage,
    mem_wb_if.src out_stage
);

    localparam int cnt_width = (warmup_cycles > 0) ? $clog2(warmup_cycles + 1) : 1;
    localparam logic [cnt_width-1:0] cnt_max = cnt_width'(warmup_cycles);

    logic [cnt_width-1:0] warm_cnt;
    logic                 warming;

    logic     valid_q;
    word_t    pc_q;
    opcode_e  opcode_q;
    func_e    func_q;
    reg_idx_t rd_q;
    word_t    result_q;
    word_t    r_data1_q;

    // The window applies to the edge at which an operation entered the
    // memory stage, so the saturation flag is delayed by one edge
    always_ff @(posedge clk) begin
        if (reset_n) begin
            warm_cnt <= '0;
            warming  <= 1'b1;
        end else begin
            if (warm_cnt != cnt_max) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
            warming <= (warm_cnt != cnt_max);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= 1'b0;
        end else if (warming) begin
            valid_q <= 1'b0; // Bubble
        end else begin
            valid_q <= in_stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q      <= in_stage.pc;
        opcode_q  <= in_stage.opcode;
        func_q    <= in_stage.func;
        rd_q      <= in_stage.rd;
        result_q  <= in_stage.result;
        r_data1_q <= in_stage.r_data1;
    end

    assign out_stage.valid   = valid_q;
    assign out_stage.pc      = pc_q;
    assign out_stage.opcode  = opcode_q;
    assign out_stage.func    = func_q;
    assign out_stage.rd      = rd_q;
    assign out_stage.result  = result_q;
    assign out_stage.r_data1 = r_data1_q;

    a_no_valid_warming: assert property (@(posedge clk) disable iff (reset_n)
        (warm_cnt != cnt_max) |=> !out_stage.valid);

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import cpu_pkg::*;
#(
    parameter int data_depth = 256
) (
    input wire    clk,
    input wire    reset_n,
    ex_mem_if.dst ex,
    mem_wb_if.src mw
);

    localparam int addr_width = $clog2(data_depth);

    logic     is_load;
    logic     is_store;
    logic     ram_we;
    word_t    ram_rdata;

    logic     valid_q;
    logic     load_q;
    word_t    pc_q;
    opcode_e  opcode_q;
    func_e    func_q;
    reg_idx_t rd_q;
    word_t    alu_q;
    word_t    r_data1_q;

    assign is_load  = (ex.opcode == op_lwd);
    assign is_store = (ex.opcode == op_swd);
    assign ram_we   = ex.valid && is_store;

    data_ram #(
        .data_depth (data_depth)
    ) ram_i (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ex.alu_result[addr_width-1:0]),
        .wdata (ex.store_data),
        .rdata (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            valid_q <= ex.valid;
            load_q  <= ex.valid && is_load;
        end
    end

    always_ff @(posedge clk) begin
        pc_q      <= ex.pc;
        opcode_q  <= ex.opcode;
        func_q    <= ex.func;
        rd_q      <= ex.rd;
        alu_q     <= ex.alu_result;
        r_data1_q <= ex.r_data1;
    end

    assign mw.valid   = valid_q;
    assign mw.pc      = pc_q;
    assign mw.opcode  = opcode_q;
    assign mw.func    = func_q;
    assign mw.rd      = rd_q;
    assign mw.result  = load_q ? ram_rdata : alu_q; // RAM word lands one edge after issue
    assign mw.r_data1 = r_data1_q;

    // Execute stage must hand over in-range addresses
    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_n)
        ex.valid && (is_load || is_store) |-> int'(ex.alu_result) < data_depth);

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import cpu_pkg::*;
#(
    parameter int  data_depth = 256,
    localparam int addr_width = $clog2(data_depth)
) (
    input  wire                  clk,
    input  wire                  we,
    input  wire [addr_width-1:0] addr,
    input  wire word_t           wdata,
    output word_t                rdata
);

    word_t mem [data_depth];

    // Read returns the old word when written on the same edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: rtl/mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if
    import cpu_pkg::*;
();

    logic     valid;
    word_t    pc;
    opcode_e  opcode;
    func_e    func;
    reg_idx_t rd;
    word_t    result;  // RAM word for loads, ALU value otherwise
    word_t    r_data1;

    modport src (
        output valid, pc, opcode, func, rd, result, r_data1
    );

    modport dst (
        input valid, pc, opcode, func, rd, result, r_data1
    );

endinterface

`default_nettype wire

// File: rtl/ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// One executed operation entering the memory stage
interface ex_mem_if
    import cpu_pkg::*;
();

    logic     valid;
    word_t    pc;
    opcode_e  opcode;
    func_e    func;
    reg_idx_t rd;
    word_t    alu_result; // Also the load/store address
    word_t    store_data;
    word_t    r_data1;

    modport src (
        output valid, pc, opcode, func, rd, alu_result, store_data, r_data1
    );

    modport dst (
        input valid, pc, opcode, func, rd, alu_result, store_data, r_data1
    );

endinterface

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_width    = 16;
    localparam int reg_idx_width = 2;
    localparam int num_regs      = 2 ** reg_idx_width;
    localparam int opcode_width  = 4;
    localparam int func_width    = 6;

    typedef logic [word_width-1:0]    word_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;

    // R-type ops all share op_rtype
    typedef enum logic [opcode_width-1:0] {
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [func_width-1:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,  // Two's complement
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_wwd = 6'd28, // Write r_data1 to the output port
        fn_hlt = 6'd29
    } func_e;

endpackage

`default_nettype wire
